//--- design/iob2axi_pkg.sv
/*
 * Shared widths, AXI encodings and enums for the IOb to AXI write bridge.
 * Referenced by scoped name from every design file.
 */
package iob2axi_pkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 16;
   localparam int AXI_LEN_W  = 8;
   localparam int STRB_W     = DATA_W / 8;
   localparam int BOUNDARY_W = 12;

   // Full-width beats, incrementing bursts
   localparam logic [2:0] AXI_SIZE       = 3'd2;
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

   // BRESP encodings
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;
   localparam logic [1:0] RESP_DECERR = 2'b11;

   typedef enum logic [1:0] {
      ADDR_HS,
      WRITE,
      W_RESPONSE
   } wr_state_e;

   typedef enum logic [1:0] {
      ST_OKAY,
      ST_SLVERR,
      ST_DECERR,
      ST_REJECT
   } wr_status_e;

endpackage

//--- design/burst_cmd_if.sv
/*
 * Command path from the decode stage to the burst engine.
 * Decode pulses start with addr and len; the engine reports idle.
 */
`timescale 1ns/1ps

interface burst_cmd_if;

   logic                                start;
   logic [iob2axi_pkg::ADDR_W-1:0]      addr;
   logic [iob2axi_pkg::AXI_LEN_W-1:0]   len;
   // High while the engine waits in ADDR_HS
   logic                                idle;

   modport decode (
      output start, addr, len,
      input  idle
   );

   modport engine (
      input  start, addr, len,
      output idle
   );

endinterface

//--- design/burst_cmd_decode.sv
/*
 * Registers run requests and checks them against AXI burst rules.
 * Legal requests become a start pulse, illegal ones a reject pulse.
 */
`timescale 1ns/1ps

module burst_cmd_decode (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                run_i,
   input  logic [iob2axi_pkg::ADDR_W-1:0]      addr_i,
   input  logic [iob2axi_pkg::AXI_LEN_W-1:0]   length_i,
   input  logic                                ready_i,
   burst_cmd_if.decode                         cmd,
   output logic                                reject_o
);

   logic                              req_q;
   logic [iob2axi_pkg::ADDR_W-1:0]    addr_q;
   logic [iob2axi_pkg::AXI_LEN_W-1:0] len_q;
   logic [iob2axi_pkg::ADDR_W:0]      last_addr;
   logic                              aligned;
   logic                              same_region;
   logic                              legal;
   logic                              accept;

   assign accept = run_i & ready_i;

   // Byte address of the final beat, one extra bit to catch wrap
   assign last_addr = {1'b0, addr_q} + ({{(iob2axi_pkg::ADDR_W + 1 -
                      iob2axi_pkg::AXI_LEN_W){1'b0}}, len_q} << 2);

   assign aligned     = (addr_q[1:0] == 2'b00);
   assign same_region = (last_addr[iob2axi_pkg::ADDR_W:iob2axi_pkg::BOUNDARY_W] ==
                         {1'b0, addr_q[iob2axi_pkg::ADDR_W-1:iob2axi_pkg::BOUNDARY_W]});
   assign legal       = aligned & same_region;

   // Request flag, held if the engine is not yet idle
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         req_q <= 1'b0;
      end else if (accept) begin
         req_q <= 1'b1;
      end else if (req_q && (!legal || cmd.idle)) begin
         req_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q <= addr_i;
         len_q  <= length_i;
      end
   end

   assign cmd.start = req_q & legal & cmd.idle;
   assign cmd.addr  = addr_q;
   assign cmd.len   = len_q;
   assign reject_o  = req_q & ~legal;

endmodule

//--- design/axi_burst_write.sv
/*
 * AXI4 write burst engine, one burst in flight.
 * Pulls beats from the IOb read port and reports the B response on done_o.
 */
`timescale 1ns/1ps

module axi_burst_write (
   input  logic                                clk_i,
   input  logic                                rst_i,
   burst_cmd_if.engine                         cmd,

   // IOb read port, word source for W beats
   output logic                                m_iob_valid_o,
   input  logic [iob2axi_pkg::DATA_W-1:0]      m_iob_rdata_i,
   input  logic [iob2axi_pkg::STRB_W-1:0]      m_iob_rstrb_i,
   input  logic                                m_iob_ready_i,

   // AXI write address
   output logic [iob2axi_pkg::ADDR_W-1:0]      m_axi_awaddr_o,
   output logic [iob2axi_pkg::AXI_LEN_W-1:0]   m_axi_awlen_o,
   output logic [2:0]                          m_axi_awsize_o,
   output logic [1:0]                          m_axi_awburst_o,
   output logic                                m_axi_awvalid_o,
   input  logic                                m_axi_awready_i,

   // AXI write data
   output logic [iob2axi_pkg::DATA_W-1:0]      m_axi_wdata_o,
   output logic [iob2axi_pkg::STRB_W-1:0]      m_axi_wstrb_o,
   output logic                                m_axi_wlast_o,
   output logic                                m_axi_wvalid_o,
   input  logic                                m_axi_wready_i,

   // AXI write response
   input  logic [1:0]                          m_axi_bresp_i,
   input  logic                                m_axi_bvalid_i,
   output logic                                m_axi_bready_o,

   output logic                                done_o,
   output logic [1:0]                          bresp_o
);

   iob2axi_pkg::wr_state_e            state_q;
   iob2axi_pkg::wr_state_e            state_n;
   logic [iob2axi_pkg::ADDR_W-1:0]    addr_q;
   logic [iob2axi_pkg::AXI_LEN_W-1:0] len_q;
   logic [iob2axi_pkg::AXI_LEN_W-1:0] count_q;
   logic                              aw_pend_q;
   logic                              launch;
   logic                              beat;
   logic                              last_beat;

   assign launch    = (state_q == iob2axi_pkg::ADDR_HS) & cmd.start;
   assign beat      = (state_q == iob2axi_pkg::WRITE) & m_iob_ready_i & m_axi_wready_i;
   assign last_beat = (count_q == len_q);

   assign cmd.idle = (state_q == iob2axi_pkg::ADDR_HS);

   // Next state
   always_comb begin
      state_n = state_q;
      case (state_q)
         iob2axi_pkg::ADDR_HS: begin
            if (cmd.start) begin
               state_n = iob2axi_pkg::WRITE;
            end
         end
         iob2axi_pkg::WRITE: begin
            if (beat && last_beat) begin
               state_n = iob2axi_pkg::W_RESPONSE;
            end
         end
         iob2axi_pkg::W_RESPONSE: begin
            if (m_axi_bvalid_i) begin
               state_n = iob2axi_pkg::ADDR_HS;
            end
         end
         default: state_n = iob2axi_pkg::ADDR_HS;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= iob2axi_pkg::ADDR_HS;
      end else begin
         state_q <= state_n;
      end
   end

   // AW stays pending until the slave takes it, may overlap the W phase
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         aw_pend_q <= 1'b0;
      end else if (launch) begin
         aw_pend_q <= ~m_axi_awready_i;
      end else if (m_axi_awready_i) begin
         aw_pend_q <= 1'b0;
      end
   end

   // Beat counter
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         count_q <= '0;
      end else if (launch) begin
         count_q <= '0;
      end else if (beat) begin
         count_q <= count_q + 1'b1;
      end
   end

   // Own copy of the command
   always_ff @(posedge clk_i) begin
      if (launch) begin
         addr_q <= cmd.addr;
         len_q  <= cmd.len;
      end
   end

   assign m_axi_awaddr_o  = launch ? cmd.addr : addr_q;
   assign m_axi_awlen_o   = launch ? cmd.len : len_q;
   assign m_axi_awsize_o  = iob2axi_pkg::AXI_SIZE;
   assign m_axi_awburst_o = iob2axi_pkg::AXI_BURST_INCR;
   assign m_axi_awvalid_o = launch | aw_pend_q;

   // Source holds the word while ready is high
   assign m_axi_wdata_o  = m_iob_rdata_i;
   assign m_axi_wstrb_o  = m_iob_rstrb_i;
   assign m_axi_wvalid_o = (state_q == iob2axi_pkg::WRITE) & m_iob_ready_i;
   assign m_axi_wlast_o  = m_axi_wvalid_o & last_beat;

   // First word on launch, then one request per accepted beat
   assign m_iob_valid_o = launch | (beat & ~last_beat);

   assign m_axi_bready_o = 1'b1;
   assign done_o         = (state_q == iob2axi_pkg::W_RESPONSE) & m_axi_bvalid_i;
   assign bresp_o        = m_axi_bresp_i;

endmodule

//--- design/write_status.sv
/*
 * Result stage: ready flag, error flag, status code and a count
 * of completed bursts, updated from done and reject events.
 */
`timescale 1ns/1ps

module write_status (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      done_i,
   input  logic [1:0]                bresp_i,
   input  logic                      reject_i,
   input  logic                      start_i,
   output logic                      ready_o,
   output logic                      error_o,
   output iob2axi_pkg::wr_status_e   status_o,
   output logic [15:0]               burst_count_o
);

   logic                    ready_q;
   iob2axi_pkg::wr_status_e resp_status;

   // EXOKAY is not expected here, treat it as OKAY
   always_comb begin
      case (bresp_i)
         iob2axi_pkg::RESP_SLVERR: resp_status = iob2axi_pkg::ST_SLVERR;
         iob2axi_pkg::RESP_DECERR: resp_status = iob2axi_pkg::ST_DECERR;
         default:                  resp_status = iob2axi_pkg::ST_OKAY;
      endcase
   end

   // Busy from the start pulse until the burst ends
   assign ready_o = ready_q & ~start_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ready_q       <= 1'b1;
         error_o       <= 1'b0;
         status_o      <= iob2axi_pkg::ST_OKAY;
         burst_count_o <= '0;
      end else begin
         if (start_i) begin
            ready_q <= 1'b0;
         end else if (done_i || reject_i) begin
            ready_q <= 1'b1;
         end
         if (done_i) begin
            status_o      <= resp_status;
            error_o       <= (resp_status != iob2axi_pkg::ST_OKAY);
            burst_count_o <= burst_count_o + 16'd1;
         end else if (reject_i) begin
            status_o <= iob2axi_pkg::ST_REJECT;
            error_o  <= 1'b1;
         end
      end
   end

endmodule

//--- design/iob2axi_write_top.sv
/*
 * Write half of the IOb to AXI4 bridge.
 * One burst per run request, data pulled from the IOb read port.
 */
`timescale 1ns/1ps

module iob2axi_write_top (
   input  logic                                clk_i,
   input  logic                                rst_i,

   // Control and status
   input  logic                                run_i,
   input  logic [iob2axi_pkg::ADDR_W-1:0]      addr_i,
   input  logic [iob2axi_pkg::AXI_LEN_W-1:0]   length_i,
   output logic                                ready_o,
   output logic                                error_o,
   output iob2axi_pkg::wr_status_e             status_o,
   output logic [15:0]                         burst_count_o,

   // IOb read port
   output logic                                m_iob_valid_o,
   input  logic [iob2axi_pkg::DATA_W-1:0]      m_iob_rdata_i,
   input  logic [iob2axi_pkg::STRB_W-1:0]      m_iob_rstrb_i,
   input  logic                                m_iob_ready_i,

   // AXI4 write channels
   output logic [iob2axi_pkg::ADDR_W-1:0]      m_axi_awaddr_o,
   output logic [iob2axi_pkg::AXI_LEN_W-1:0]   m_axi_awlen_o,
   output logic [2:0]                          m_axi_awsize_o,
   output logic [1:0]                          m_axi_awburst_o,
   output logic                                m_axi_awvalid_o,
   input  logic                                m_axi_awready_i,
   output logic [iob2axi_pkg::DATA_W-1:0]      m_axi_wdata_o,
   output logic [iob2axi_pkg::STRB_W-1:0]      m_axi_wstrb_o,
   output logic                                m_axi_wlast_o,
   output logic                                m_axi_wvalid_o,
   input  logic                                m_axi_wready_i,
   input  logic [1:0]                          m_axi_bresp_i,
   input  logic                                m_axi_bvalid_i,
   output logic                                m_axi_bready_o
);

   logic       reject;
   logic       done;
   logic [1:0] bresp;

   burst_cmd_if cmd_if ();

   burst_cmd_decode i_burst_cmd_decode (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .run_i    (run_i),
      .addr_i   (addr_i),
      .length_i (length_i),
      .ready_i  (ready_o),
      .cmd      (cmd_if.decode),
      .reject_o (reject)
   );

   axi_burst_write i_axi_burst_write (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cmd             (cmd_if.engine),
      .m_iob_valid_o   (m_iob_valid_o),
      .m_iob_rdata_i   (m_iob_rdata_i),
      .m_iob_rstrb_i   (m_iob_rstrb_i),
      .m_iob_ready_i   (m_iob_ready_i),
      .m_axi_awaddr_o  (m_axi_awaddr_o),
      .m_axi_awlen_o   (m_axi_awlen_o),
      .m_axi_awsize_o  (m_axi_awsize_o),
      .m_axi_awburst_o (m_axi_awburst_o),
      .m_axi_awvalid_o (m_axi_awvalid_o),
      .m_axi_awready_i (m_axi_awready_i),
      .m_axi_wdata_o   (m_axi_wdata_o),
      .m_axi_wstrb_o   (m_axi_wstrb_o),
      .m_axi_wlast_o   (m_axi_wlast_o),
      .m_axi_wvalid_o  (m_axi_wvalid_o),
      .m_axi_wready_i  (m_axi_wready_i),
      .m_axi_bresp_i   (m_axi_bresp_i),
      .m_axi_bvalid_i  (m_axi_bvalid_i),
      .m_axi_bready_o  (m_axi_bready_o),
      .done_o          (done),
      .bresp_o         (bresp)
   );

   // Start pulse taken from the command path
   write_status i_write_status (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .done_i        (done),
      .bresp_i       (bresp),
      .reject_i      (reject),
      .start_i       (cmd_if.start),
      .ready_o       (ready_o),
      .error_o       (error_o),
      .status_o      (status_o),
      .burst_count_o (burst_count_o)
   );

endmodule

//--- verification/iob2axi_write_asserts.sv
/*
 * Protocol checks on the AXI write address and data channels.
 * Bound into every axi_burst_write instance and counts its own failures.
 */
`timescale 1ns/1ps

module iob2axi_write_asserts (
   input logic                                clk_i,
   input logic                                rst_i,
   input logic                                awvalid_i,
   input logic                                awready_i,
   input logic [iob2axi_pkg::ADDR_W-1:0]      awaddr_i,
   input logic [iob2axi_pkg::AXI_LEN_W-1:0]   awlen_i,
   input logic                                wvalid_i,
   input logic                                wready_i,
   input logic [iob2axi_pkg::DATA_W-1:0]      wdata_i,
   input logic                                wlast_i,
   input logic                                idle_i,
   input logic                                launch_i
);

   int                                failures = 0;
   logic [iob2axi_pkg::AXI_LEN_W-1:0] beats_q;

   // W beats accepted so far in the current burst
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         beats_q <= '0;
      end else if (wvalid_i && wready_i) begin
         beats_q <= wlast_i ? '0 : beats_q + 1'b1;
      end
   end

   // Address held stable until the slave takes it
   assert property (@(posedge clk_i) disable iff (rst_i)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
      else begin
         $error("AWVALID or AW payload changed before AWREADY");
         failures++;
      end

   assert property (@(posedge clk_i) disable iff (rst_i)
      wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
      else begin
         $error("WVALID or W payload changed before WREADY");
         failures++;
      end

   // WLAST only with WVALID and only on beat awlen+1
   assert property (@(posedge clk_i) disable iff (rst_i)
      wlast_i |-> wvalid_i && (beats_q == awlen_i))
      else begin
         $error("WLAST without WVALID or not on the last beat");
         failures++;
      end

   // In the idle state only the launch cycle may show AWVALID
   assert property (@(posedge clk_i) disable iff (rst_i) awvalid_i && idle_i |-> launch_i)
      else begin
         $error("AWVALID while the engine is idle");
         failures++;
      end

endmodule

bind axi_burst_write iob2axi_write_asserts i_write_asserts (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .awvalid_i (m_axi_awvalid_o),
   .awready_i (m_axi_awready_i),
   .awaddr_i  (m_axi_awaddr_o),
   .awlen_i   (m_axi_awlen_o),
   .wvalid_i  (m_axi_wvalid_o),
   .wready_i  (m_axi_wready_i),
   .wdata_i   (m_axi_wdata_o),
   .wlast_i   (m_axi_wlast_o),
   .idle_i    (state_q == iob2axi_pkg::ADDR_HS),
   .launch_i  (launch)
);

//--- verification/tb_iob2axi_write.sv
/*
 * Testbench for the IOb to AXI write bridge, with an IOb word source and an
 * AXI slave that applies random back-pressure and a chosen write response.
 */
`timescale 1ns/1ps

module tb_iob2axi_write;

   localparam int CLK_PERIOD = 4;
   localparam int NUM_TESTS  = 14;
   localparam int TIMEOUT_NS = NUM_TESTS * (256 + 20) * 4 * CLK_PERIOD;

   logic                    clk_i;
   logic                    rst_i;
   logic                    run_i;
   logic [15:0]             addr_i;
   logic [7:0]              length_i;
   logic                    ready_o;
   logic                    error_o;
   iob2axi_pkg::wr_status_e status_o;
   logic [15:0]             burst_count_o;
   logic                    m_iob_valid_o;
   logic [31:0]             m_iob_rdata_i;
   logic [3:0]              m_iob_rstrb_i;
   logic                    m_iob_ready_i;
   logic [15:0]             m_axi_awaddr_o;
   logic [7:0]              m_axi_awlen_o;
   logic [2:0]              m_axi_awsize_o;
   logic [1:0]              m_axi_awburst_o;
   logic                    m_axi_awvalid_o;
   logic                    m_axi_awready_i;
   logic [31:0]             m_axi_wdata_o;
   logic [3:0]              m_axi_wstrb_o;
   logic                    m_axi_wlast_o;
   logic                    m_axi_wvalid_o;
   logic                    m_axi_wready_i;
   logic [1:0]              m_axi_bresp_i;
   logic                    m_axi_bvalid_i;
   logic                    m_axi_bready_o;

   integer      seed;
   string       test_name;
   logic [15:0] cur_addr;
   logic [7:0]  cur_len;
   logic [1:0]  cur_resp;
   int          src_k;
   int          beat_k;
   int          awvalid_cycles;
   int          exp_count;
   logic        aw_seen;
   logic        w_seen;

   iob2axi_write_top i_iob2axi_write_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp == act) else begin
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
         $display("Simulation failed");
         $fatal;
      end
   endtask

   // IOb source and AXI slave sample on the edge and drive 1 ns later
   always begin : bus_models
      logic aw_hs;
      logic w_hs;
      logic iob_req;
      @(posedge clk_i);
      aw_hs   = m_axi_awvalid_o & m_axi_awready_i;
      w_hs    = m_axi_wvalid_o & m_axi_wready_i;
      iob_req = m_iob_valid_o;
      if (m_axi_awvalid_o) begin
         awvalid_cycles++;
      end
      if (aw_hs) begin
         check_value({test_name, " awaddr"}, cur_addr, m_axi_awaddr_o);
         check_value({test_name, " awlen"}, cur_len, m_axi_awlen_o);
         // Full-width beats in INCR bursts
         check_value({test_name, " awsize"}, 3'd2, m_axi_awsize_o);
         check_value({test_name, " awburst"}, 2'b01, m_axi_awburst_o);
         aw_seen = 1'b1;
      end
      if (w_hs) begin
         check_value({test_name, " wdata"}, 32'(cur_addr) + 32'(4 * beat_k), m_axi_wdata_o);
         check_value({test_name, " wlast"}, (beat_k == cur_len), m_axi_wlast_o);
         check_value({test_name, " wstrb"}, 4'hf, m_axi_wstrb_o);
         w_seen = w_seen | m_axi_wlast_o;
         beat_k++;
      end
      if (m_axi_bvalid_i) begin
         check_value({test_name, " bready"}, 1, m_axi_bready_o);
      end
      #1;
      // BREADY is always high, so BVALID lasts one cycle
      if (m_axi_bvalid_i) begin
         m_axi_bvalid_i = 1'b0;
      end else if (aw_seen && w_seen) begin
         m_axi_bvalid_i = 1'b1;
         m_axi_bresp_i  = cur_resp;
         aw_seen        = 1'b0;
         w_seen         = 1'b0;
      end
      if (iob_req) begin
         m_iob_rdata_i = 32'(cur_addr) + 32'(4 * src_k);
         m_iob_ready_i = 1'b1;
         src_k++;
      end else if (w_hs) begin
         m_iob_ready_i = 1'b0;
      end
      m_axi_awready_i = $random(seed);
      m_axi_wready_i  = $random(seed);
   end

   task automatic run_burst(input string name, input logic [15:0] addr, input logic [7:0] len,
                            input logic [1:0] resp, input iob2axi_pkg::wr_status_e exp_status);
      int awv_before;
      bit rejected;
      rejected = (exp_status == iob2axi_pkg::ST_REJECT);
      @(posedge clk_i);
      #1;
      test_name  = name;
      cur_addr   = addr;
      cur_len    = len;
      cur_resp   = resp;
      src_k      = 0;
      beat_k     = 0;
      awv_before = awvalid_cycles;
      run_i      = 1'b1;
      addr_i     = addr;
      length_i   = len;
      @(posedge clk_i);
      #1;
      run_i = 1'b0;
      @(posedge clk_i);
      if (rejected) begin
         check_value({name, " ready held"}, 1, ready_o);
      end
      do begin
         @(posedge clk_i);
      end while (!ready_o);
      if (rejected) begin
         check_value({name, " no awvalid"}, awv_before, awvalid_cycles);
      end else begin
         exp_count++;
         check_value({name, " beats"}, 32'(len) + 1, beat_k);
      end
      check_value({name, " status"}, exp_status, status_o);
      check_value({name, " error"}, (exp_status != iob2axi_pkg::ST_OKAY), error_o);
      check_value({name, " count"}, exp_count, burst_count_o);
   endtask

   initial begin
      int region;
      int len;
      int word;
      seed            = 71;
      rst_i           = 1'b1;
      run_i           = 1'b0;
      addr_i          = '0;
      length_i        = '0;
      m_iob_rdata_i   = '0;
      m_iob_rstrb_i   = 4'hf;
      m_iob_ready_i   = 1'b0;
      m_axi_awready_i = 1'b0;
      m_axi_wready_i  = 1'b0;
      m_axi_bresp_i   = 2'b00;
      m_axi_bvalid_i  = 1'b0;
      awvalid_cycles  = 0;
      exp_count       = 0;
      aw_seen         = 1'b0;
      w_seen          = 1'b0;
      test_name       = "reset";
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      @(posedge clk_i);
      check_value("reset ready", 1, ready_o);
      check_value("reset error", 0, error_o);
      check_value("reset awvalid", 0, m_axi_awvalid_o);
      check_value("reset wvalid", 0, m_axi_wvalid_o);
      check_value("reset wlast", 0, m_axi_wlast_o);
      check_value("reset iob valid", 0, m_iob_valid_o);
      check_value("reset status", iob2axi_pkg::ST_OKAY, status_o);
      check_value("reset count", 0, burst_count_o);

      run_burst("single_beat", 16'h0100, 8'd0,
                iob2axi_pkg::RESP_OKAY, iob2axi_pkg::ST_OKAY);
      // Random bursts placed inside one 4 KB region
      for (int i = 0; i < 8; i++) begin
         region = $random(seed) & 15;
         len    = $random(seed) & 255;
         word   = $unsigned($random(seed)) % (1024 - len);
         run_burst("random_len", 16'((region << 12) | (word << 2)), 8'(len),
                   iob2axi_pkg::RESP_OKAY, iob2axi_pkg::ST_OKAY);
      end
      run_burst("resp_slverr", 16'h2000, 8'd3,
                iob2axi_pkg::RESP_SLVERR, iob2axi_pkg::ST_SLVERR);
      run_burst("resp_decerr", 16'h3040, 8'd1,
                iob2axi_pkg::RESP_DECERR, iob2axi_pkg::ST_DECERR);
      run_burst("resp_okay", 16'h4000, 8'd2,
                iob2axi_pkg::RESP_OKAY, iob2axi_pkg::ST_OKAY);
      run_burst("reject_4k", 16'h0ff0, 8'd7,
                iob2axi_pkg::RESP_OKAY, iob2axi_pkg::ST_REJECT);
      run_burst("reject_unaligned", 16'h0202, 8'd0,
                iob2axi_pkg::RESP_OKAY, iob2axi_pkg::ST_REJECT);

      if (i_iob2axi_write_top.i_axi_burst_write.i_write_asserts.failures == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal;
      end
   end

   // Stop at the first bound protocol assertion that fires
   always @(negedge clk_i) begin
      if (i_iob2axi_write_top.i_axi_burst_write.i_write_asserts.failures != 0) begin
         $display("A protocol assertion on the AXI write channels failed");
         $display("Simulation failed");
         $fatal;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the bridge did not finish all bursts in time");
      $display("Simulation failed");
      $fatal;
   end

endmodule

//--- all.f
design/iob2axi_pkg.sv
design/burst_cmd_if.sv
design/burst_cmd_decode.sv
design/axi_burst_write.sv
design/write_status.sv
design/iob2axi_write_top.sv
verification/iob2axi_write_asserts.sv
verification/tb_iob2axi_write.sv

//--- Bender.yml
package:
  name: iob2axi_write

sources:
  - design/iob2axi_pkg.sv
  - design/burst_cmd_if.sv
  - design/burst_cmd_decode.sv
  - design/axi_burst_write.sv
  - design/write_status.sv
  - design/iob2axi_write_top.sv
  - target: test
    files:
      - verification/iob2axi_write_asserts.sv
      - verification/tb_iob2axi_write.sv
